/* filelist.f */
hdl/qla_pkg.sv
hdl/ctrl_enc.sv
hdl/ctrl_dac.sv
hdl/board_regs.sv
hdl/reg_read_router.sv
hdl/qla_top.sv
verification/tb_qla_top.sv

/* hdl/board_regs.sv */
/*
 * board register block, channel 0
 *   amp enables, power, relay, digital outputs
 *   synchronized limit/home/fault status, write-activity watchdog
 */

`timescale 1ns/1ps

module board_regs import qla_pkg::*; #(
    parameter int WDOG_UNIT_W = 8
) (
    input  logic       sysclk,
    input  logic       rst_n,
    input  reg_bus_t   host,
    input  logic [3:0] board_id,
    input  board_in_t  board_in,
    output reg_data_t  board_rdata,
    output axis_mask_t amp_disable,
    output logic       pwr_enable,
    output logic       relay_on,
    output logic [3:0] dout
);

    board_in_t in_s1, in_s2;                        // two-flop sync

    logic ctrl_wr, wdog_wr;
    logic wdog_to;                                  // timeout flag
    logic unit_tick, expire;

    logic [15:0]            wdog_period;            // 0 = disabled
    logic [15:0]            wdog_cnt;
    logic [WDOG_UNIT_W-1:0] unit_cnt;

    assign ctrl_wr = host.wen && host.addr == {4'h0, ofs_status};
    assign wdog_wr = host.wen && host.addr == {4'h0, ofs_wdog};

    assign unit_tick = &unit_cnt;
    assign expire    = unit_tick && wdog_cnt == wdog_period - 16'd1;

    // ------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            in_s1       <= '0;
            in_s2       <= '0;
            amp_disable <= '1;                      // amps off out of reset
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            dout        <= '0;
            wdog_period <= '0;
            wdog_cnt    <= '0;
            unit_cnt    <= '0;
            wdog_to     <= 1'b0;
        end else begin
            in_s1 <= board_in;
            in_s2 <= in_s1;

            if (wdog_wr) wdog_period <= host.wdata[15:0];

            if (host.wen) begin                     // any write kicks the dog
                unit_cnt <= '0;
                wdog_cnt <= '0;
            end else if (wdog_period != 16'd0 && !wdog_to) begin
                unit_cnt <= unit_cnt + 1'b1;
                if (unit_tick) wdog_cnt <= wdog_cnt + 1'b1;
            end

            if (ctrl_wr) begin
                amp_disable <= host.wdata[3:0];
                pwr_enable  <= host.wdata[4];
                relay_on    <= host.wdata[5];
                dout        <= host.wdata[11:8];
                wdog_to     <= 1'b0;
            end else if (wdog_period != 16'd0 && !wdog_to && expire) begin
                amp_disable <= '1;                  // expiry shuts all amps
                wdog_to     <= 1'b1;
            end
        end
    end

    // status word / watchdog period readback
    always_comb begin
        board_rdata = '0;
        if (host.addr == {4'h0, ofs_status})
            board_rdata = {board_id, in_s2.neg_limit, in_s2.pos_limit, in_s2.home,
                           in_s2.fault, dout, 1'b0, wdog_to, relay_on, pwr_enable,
                           amp_disable};
        else if (host.addr == {4'h0, ofs_wdog})
            board_rdata = {16'h0000, wdog_period};
    end

endmodule

/* hdl/ctrl_dac.sv */
/*
 * DAC controller
 *   command register and pending flag per axis
 *   24-bit serial frame shifter, header 0x3n then 16-bit value
 */

`timescale 1ns/1ps

module ctrl_dac import qla_pkg::*; #(
    parameter int DAC_SCLK_DIV = 2                  // cycles per sclk half period
) (
    input  logic      sysclk,
    input  logic      rst_n,
    input  reg_bus_t  host,
    output reg_data_t dac_rdata,
    output logic      dac_sclk,
    output logic      dac_mosi,
    output logic      dac_csel
);

    localparam int div_w = (DAC_SCLK_DIV > 1) ? $clog2(DAC_SCLK_DIV) : 1;

    dac_value_t cmd [num_axes];
    axis_mask_t pending;
    axis_mask_t set_mask, clr_mask;
    axis_idx_t  next_axis;                          // lowest pending axis
    logic       dac_wr;
    axis_idx_t  wr_axis;

    dac_state_t       state;
    logic [23:0]      shreg;
    logic [div_w-1:0] div_cnt;
    logic [4:0]       bit_cnt;

    assign dac_wr   = host.wen && axis_hit(host.addr, ofs_dac);
    assign wr_axis  = axis_of(host.addr);
    assign set_mask = dac_wr ? axis_mask_t'(1) << wr_axis : '0;

    always_comb begin
        next_axis = '0;
        for (int i = num_axes - 1; i >= 0; i--)
            if (pending[i]) next_axis = axis_idx_t'(i);
    end

    // flag taken when the frame loads
    assign clr_mask = (state == idle && |pending) ? axis_mask_t'(1) << next_axis : '0;

    // ------------------------------------------------------------
    // command storage and serializer
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_axes; i++) cmd[i] <= '0;
            pending  <= '0;
            state    <= idle;
            shreg    <= '0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            dac_sclk <= 1'b0;
            dac_csel <= 1'b1;
        end else begin
            if (dac_wr)
                cmd[wr_axis] <= host.wdata[15:0];
            pending <= (pending & ~clr_mask) | set_mask; // new write keeps its flag

            case (state)
                idle: if (|pending) begin
                    shreg    <= {4'h3, 4'(next_axis), cmd[next_axis]};
                    dac_csel <= 1'b0;
                    div_cnt  <= '0;
                    bit_cnt  <= '0;
                    state    <= shift;
                end
                shift: if (div_cnt == div_w'(DAC_SCLK_DIV - 1)) begin
                    div_cnt  <= '0;
                    dac_sclk <= ~dac_sclk;
                    if (dac_sclk) begin             // falling edge, next bit out
                        shreg <= shreg << 1;
                        if (bit_cnt == 5'd23) begin
                            dac_csel <= 1'b1;       // end of frame
                            state    <= gap;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
                gap: state <= idle;                 // csel high through gap + idle
                default: state <= idle;
            endcase
        end
    end

    assign dac_mosi = shreg[23];                    // msb first

    assign dac_rdata = axis_hit(host.addr, ofs_dac) ? {16'h0000, cmd[axis_of(host.addr)]}
                                                    : '0;

endmodule

/* hdl/ctrl_enc.sv */
/*
 * encoder controller, four axes
 *   two-flop input synchronizers, quadrature up/down counters
 *   preload writes, period tick divider and period capture on rising A
 */

`timescale 1ns/1ps

module ctrl_enc import qla_pkg::*; #(
    parameter int ENC_TICK_W = 4
) (
    input  logic       sysclk,
    input  logic       rst_n,
    input  reg_bus_t   host,
    input  axis_mask_t enc_a,
    input  axis_mask_t enc_b,
    output reg_data_t  enc_rdata
);

    axis_mask_t a_s1, a_s2, a_d;                    // sync stages + previous state
    axis_mask_t b_s1, b_s2, b_d;
    axis_mask_t step_a, step_b;
    axis_mask_t step_ok, dir_up, rise_a;

    logic [ENC_TICK_W-1:0] tick_div;
    logic                  tick;

    enc_count_t count    [num_axes];
    period_t    tick_cnt [num_axes];                // ticks since last rising A
    period_t    period_q [num_axes];

    logic      preload_wr;
    axis_idx_t wr_axis;
    axis_idx_t rd_axis;

    // ------------------------------------------------------------
    // synchronizers and step decode
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            a_s1 <= '0;
            a_s2 <= '0;
            a_d  <= '0;
            b_s1 <= '0;
            b_s2 <= '0;
            b_d  <= '0;
        end else begin
            a_s1 <= enc_a;
            a_s2 <= a_s1;
            a_d  <= a_s2;
            b_s1 <= enc_b;
            b_s2 <= b_s1;
            b_d  <= b_s2;
        end
    end

    assign step_a  = a_s2 ^ a_d;
    assign step_b  = b_s2 ^ b_d;
    assign step_ok = step_a ^ step_b;               // double change is dropped
    // a moved: up when a != b; b moved: up when a == b
    assign dir_up  = a_s2 ^ b_s2 ^ step_b;
    assign rise_a  = a_s2 & ~a_d;

    assign preload_wr = host.wen && axis_hit(host.addr, ofs_preload);
    assign wr_axis    = axis_of(host.addr);
    assign rd_axis    = axis_of(host.addr);

    // free-running period time base
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            tick_div <= '0;
        else
            tick_div <= tick_div + 1'b1;
    end

    assign tick = &tick_div;                        // one strobe per 2^ENC_TICK_W

    // ------------------------------------------------------------
    // position count and period per axis
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_axes; i++) begin
                count[i]    <= '0;
                tick_cnt[i] <= '0;
                period_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_axes; i++) begin
                if (preload_wr && wr_axis == axis_idx_t'(i))
                    count[i] <= host.wdata[23:0];   // preload wins over a step
                else if (step_ok[i])
                    count[i] <= dir_up[i] ? count[i] + 1'b1 : count[i] - 1'b1;

                if (rise_a[i]) begin
                    period_q[i] <= tick_cnt[i];
                    tick_cnt[i] <= '0;
                end else if (tick && !(&tick_cnt[i])) begin
                    tick_cnt[i] <= tick_cnt[i] + 1'b1; // saturate at all ones
                end
            end
        end
    end

    // readback, zero-extended
    always_comb begin
        enc_rdata = '0;
        if (axis_hit(host.addr, ofs_preload) || axis_hit(host.addr, ofs_quad))
            enc_rdata = {8'h00, count[rd_axis]};
        else if (axis_hit(host.addr, ofs_period))
            enc_rdata = {16'h0000, period_q[rd_axis]};
    end

endmodule

/* hdl/qla_pkg.sv */
/*
 * shared definitions for the motor-axis controller core
 *   bus and field typedefs, host bus struct, board input struct
 *   register offsets, axis decode helpers, DAC serializer states
 */

package qla_pkg;

    localparam int num_axes = 4;                    // motor axes on the board

    // ------------------------------------------------------------
    // widths with a meaning
    typedef logic [7:0]                   reg_addr_t;  // [7:4] channel, [3:0] offset
    typedef logic [31:0]                  reg_data_t;
    typedef logic [num_axes-1:0]          axis_mask_t; // one bit per axis
    typedef logic [$clog2(num_axes)-1:0]  axis_idx_t;
    typedef logic [23:0]                  enc_count_t; // quadrature position
    typedef logic [15:0]                  period_t;    // encoder period in ticks
    typedef logic [15:0]                  dac_value_t;

    // host register bus, same struct fans out to every block
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t wdata;
        logic      wen;                             // single-cycle write pulse
    } reg_bus_t;

    // board status pins, grouped per function
    typedef struct packed {
        axis_mask_t neg_limit;
        axis_mask_t pos_limit;
        axis_mask_t home;
        axis_mask_t fault;
    } board_in_t;

    // ------------------------------------------------------------
    // register offsets (low nibble)
    localparam logic [3:0] ofs_status  = 4'd0;     // channel 0 only
    localparam logic [3:0] ofs_dac     = 4'd1;
    localparam logic [3:0] ofs_wdog    = 4'd3;     // channel 0 only
    localparam logic [3:0] ofs_preload = 4'd4;
    localparam logic [3:0] ofs_quad    = 4'd5;
    localparam logic [3:0] ofs_period  = 4'd6;

    // true for channels 1..num_axes at the given offset
    function automatic logic axis_hit(reg_addr_t addr, logic [3:0] ofs);
        return (addr[7:4] >= 4'd1) && (addr[7:4] <= 4'(num_axes)) && (addr[3:0] == ofs);
    endfunction

    // channel n maps to axis n-1
    function automatic axis_idx_t axis_of(reg_addr_t addr);
        return axis_idx_t'(addr[7:4] - 4'd1);
    endfunction

    typedef enum logic [1:0] {idle, shift, gap} dac_state_t;

endpackage

/* hdl/qla_top.sv */
/*
 * top level of the motor-axis controller core
 *   encoder, DAC and board register controllers
 *   plus the registered read-data router
 */

`timescale 1ns/1ps

module qla_top import qla_pkg::*; #(
    parameter int ENC_TICK_W   = 4,                 // period tick = 2^ENC_TICK_W cycles
    parameter int DAC_SCLK_DIV = 2,                 // half sclk period in cycles
    parameter int WDOG_UNIT_W  = 8                  // watchdog unit = 2^WDOG_UNIT_W cycles
) (
    input  logic       sysclk,
    input  logic       rst_n,
    input  reg_bus_t   host,
    input  logic [3:0] board_id,
    input  board_in_t  board_in,
    input  axis_mask_t enc_a,
    input  axis_mask_t enc_b,
    output reg_data_t  reg_rdata,
    output logic       dac_sclk,
    output logic       dac_mosi,
    output logic       dac_csel,
    output axis_mask_t amp_disable,
    output logic       pwr_enable,
    output logic       relay_on,
    output logic [3:0] dout
);

    reg_data_t enc_rdata;                           // per-controller read data
    reg_data_t dac_rdata;
    reg_data_t board_rdata;

    // encoders ---------------------------------------------------
    ctrl_enc #(.ENC_TICK_W(ENC_TICK_W)) i_ctrl_enc (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .host      (host),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .enc_rdata (enc_rdata)
    );

    // dacs -------------------------------------------------------
    ctrl_dac #(.DAC_SCLK_DIV(DAC_SCLK_DIV)) i_ctrl_dac (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .host      (host),
        .dac_rdata (dac_rdata),
        .dac_sclk  (dac_sclk),
        .dac_mosi  (dac_mosi),
        .dac_csel  (dac_csel)
    );

    // channel 0, board i/o and watchdog
    board_regs #(.WDOG_UNIT_W(WDOG_UNIT_W)) i_board_regs (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .host        (host),
        .board_id    (board_id),
        .board_in    (board_in),
        .board_rdata (board_rdata),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable),
        .relay_on    (relay_on),
        .dout        (dout)
    );

    reg_read_router i_reg_read_router (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .addr        (host.addr),
        .enc_rdata   (enc_rdata),
        .dac_rdata   (dac_rdata),
        .board_rdata (board_rdata),
        .reg_rdata   (reg_rdata)
    );

endmodule

/* hdl/reg_read_router.sv */
/*
 * read-data router
 *   decodes the owner of the addressed register
 *   and registers its data, one cycle latency
 */

`timescale 1ns/1ps

module reg_read_router import qla_pkg::*; (
    input  logic      sysclk,
    input  logic      rst_n,
    input  reg_addr_t addr,
    input  reg_data_t enc_rdata,
    input  reg_data_t dac_rdata,
    input  reg_data_t board_rdata,
    output reg_data_t reg_rdata
);

    reg_data_t rdata_sel;

    // channel 0 is the board, channels 1..4 the axes
    always_comb begin
        rdata_sel = '0;                             // unmapped reads as zero
        if (addr == {4'h0, ofs_status} || addr == {4'h0, ofs_wdog})
            rdata_sel = board_rdata;
        else if (axis_hit(addr, ofs_dac))
            rdata_sel = dac_rdata;
        else if (axis_hit(addr, ofs_preload) || axis_hit(addr, ofs_quad) ||
                 axis_hit(addr, ofs_period))
            rdata_sel = enc_rdata;                  // preload, quad, period
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            reg_rdata <= '0;
        else
            reg_rdata <= rdata_sel;                 // valid one cycle after addr
    end

endmodule

/* verification/tb_qla_top.sv */
/*
 * testbench for the motor-axis controller core
 *   table of register ops applied in a loop, quadrature and A-period drivers
 *   DAC frame monitor, value check task, cycle-count timeout
 */

`timescale 1ns/1ps

module tb_qla_top import qla_pkg::*; ();

    localparam int enc_tick_w   = 4;                // DUT defaults
    localparam int dac_sclk_div = 2;
    localparam logic [19:0] pins_in = 20'h68421;    // id 6, neg 8, pos 4, home 2, fault 1

    typedef enum logic [3:0] {
        op_wr, op_rd, op_near, op_pins, op_in, op_fwd, op_bwd, op_dbl,
        op_aper, op_wait, op_frame, op_done
    } op_t;

    typedef struct packed {
        op_t       op;
        reg_addr_t addr;
        reg_data_t data;
        reg_data_t exp;                             // expected value if any
    } step_t;

    logic       sysclk, rst_n;
    reg_bus_t   host;
    logic [3:0] board_id;
    board_in_t  board_in;
    axis_mask_t enc_a, enc_b;
    reg_data_t  reg_rdata;
    logic       dac_sclk, dac_mosi, dac_csel;
    axis_mask_t amp_disable;
    logic       pwr_enable, relay_on;
    logic [3:0] dout;

    step_t       steps[$];
    string       test_names[$];
    logic [23:0] frames[$];                         // captured dac frames
    logic [23:0] frame_sr;
    int          frame_bits = 0;
    int          n_tests = 0, n_checks = 0, n_errors = 0, test_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    always #50 sysclk = ~sysclk;                    // 100 ns period

    qla_top i_qla_top (.*);

    // ------------------------------------------------------------
    // dac monitor samples mosi on rising sclk while csel low
    always @(posedge dac_sclk or posedge dac_csel) begin
        if (dac_csel) begin
            frame_bits = 0;                         // resync at frame end
        end else begin
            frame_sr = {frame_sr[22:0], dac_mosi};
            frame_bits++;
            if (frame_bits == 24) begin
                frames.push_back(frame_sr);
                frame_bits = 0;
            end
        end
    end

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: table not finished within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // expected words from the register layout
    function automatic reg_data_t status_word(logic [19:0] pins, logic [3:0] dout_v,
                                              logic to, logic relay, logic pwr,
                                              logic [3:0] amp);
        reg_data_t w;
        w        = '0;
        w[3:0]   = amp;
        w[4]     = pwr;
        w[5]     = relay;
        w[6]     = to;                              // watchdog timeout
        w[11:8]  = dout_v;
        w[15:12] = pins[3:0];                       // fault
        w[19:16] = pins[7:4];                       // home
        w[23:20] = pins[11:8];                      // pos limit
        w[27:24] = pins[15:12];                     // neg limit
        w[31:28] = pins[19:16];                     // board id
        return w;
    endfunction

    function automatic reg_data_t pins_word(logic [3:0] dout_v, logic relay, logic pwr,
                                            logic [3:0] amp, logic sclk, logic mosi,
                                            logic csel);
        return {19'b0, dout_v, relay, pwr, amp, sclk, mosi, csel};
    endfunction

    function automatic reg_data_t frame_word(int axis, logic [15:0] value);
        return {8'h00, 4'h3, 4'(axis), value};      // header nibble 3 then axis index
    endfunction

    function automatic int step_cost(step_t s);
        case (s.op)
            op_wait:        return s.data;
            op_fwd, op_bwd: return 5 * s.data;
            op_aper:        return 4 * s.data;
            op_frame:       return 24 * 2 * dac_sclk_div + 4;
            default:        return 6;
        endcase
    endfunction

    task automatic check(string name, reg_data_t got, reg_data_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            n_errors++;
            test_errors++;
        end
    endtask

    // one gray step where +1 means A leads B
    task automatic quad_step(int axis, int delta);
        int ph;
        ph = {enc_b[axis], enc_a[axis]} == 2'b00 ? 0 :
             {enc_b[axis], enc_a[axis]} == 2'b01 ? 1 :
             {enc_b[axis], enc_a[axis]} == 2'b11 ? 2 : 3;
        ph = (ph + delta) & 3;
        enc_a[axis] <= (ph == 1 || ph == 2);
        enc_b[axis] <= (ph >= 2);
        repeat (4) @(posedge sysclk);               // sync + count settle
    endtask

    task automatic a_period(int axis, int spacing);
        repeat (4) begin
            enc_a[axis] <= 1'b1;
            repeat (spacing / 2) @(posedge sysclk);
            enc_a[axis] <= 1'b0;
            repeat (spacing - spacing / 2) @(posedge sysclk);
        end
    endtask

    task automatic add_step(op_t op, reg_addr_t addr, reg_data_t data, reg_data_t exp);
        steps.push_back('{op: op, addr: addr, data: data, exp: exp});
    endtask

    task automatic end_test(string name);
        test_names.push_back(name);
        add_step(op_done, 8'h00, 0, 0);
    endtask

    // ------------------------------------------------------------
    task automatic build_steps();
        add_step(op_rd, 8'h00, 0, status_word(20'h0, 4'h0, 1'b0, 1'b0, 1'b0, 4'hf));
        for (int ch = 1; ch <= num_axes; ch++) begin
            add_step(op_rd, {4'(ch), ofs_dac}, 0, 0);
            add_step(op_rd, {4'(ch), ofs_quad}, 0, 0);
            add_step(op_rd, {4'(ch), ofs_period}, 0, 0);
        end
        add_step(op_rd, 8'h03, 0, 0);               // watchdog off
        add_step(op_pins, 8'h00, 0,
                 pins_word(4'h0, 1'b0, 1'b0, 4'hf, 1'b0, 1'b0, 1'b1));
        end_test("reset state");

        add_step(op_wr, 8'h00, 32'h0000_0a35, 0);
        add_step(op_pins, 8'h00, 0,
                 pins_word(4'ha, 1'b1, 1'b1, 4'h5, 1'b0, 1'b0, 1'b1));
        add_step(op_in, 8'h00, pins_in, 0);
        add_step(op_rd, 8'h00, 0, status_word(pins_in, 4'ha, 1'b0, 1'b1, 1'b1, 4'h5));
        add_step(op_rd, 8'h07, 0, 0);               // unmapped
        add_step(op_rd, 8'h51, 0, 0);
        end_test("board control");

        add_step(op_wr, 8'h41, 32'h1234, 0);        // axis 3 then axis 1 back to back
        add_step(op_wr, 8'h21, 32'hbeef, 0);
        add_step(op_wait, 8'h00, 10, 0);
        add_step(op_wr, 8'h31, 32'h0f0f, 0);        // during first frame
        add_step(op_wr, 8'h21, 32'h5a5a, 0);
        add_step(op_wr, 8'h11, 32'h8001, 0);
        add_step(op_rd, 8'h11, 0, 32'h8001);
        add_step(op_rd, 8'h21, 0, 32'h5a5a);
        add_step(op_rd, 8'h31, 0, 32'h0f0f);
        add_step(op_rd, 8'h41, 0, 32'h1234);
        add_step(op_frame, 8'h00, 0, frame_word(3, 16'h1234));
        add_step(op_frame, 8'h00, 0, frame_word(0, 16'h8001));
        add_step(op_frame, 8'h00, 0, frame_word(1, 16'h5a5a));
        add_step(op_frame, 8'h00, 0, frame_word(2, 16'h0f0f));
        end_test("dac frames");

        add_step(op_wr, 8'h34, 32'hab_fffffa, 0);   // high byte dropped
        add_step(op_rd, 8'h35, 0, 32'h00_fffffa);
        add_step(op_fwd, 8'h30, 12, 0);
        add_step(op_dbl, 8'h30, 0, 0);
        add_step(op_bwd, 8'h30, 3, 0);
        add_step(op_rd, 8'h35, 0, 24'(24'hfffffa + 12 - 3));
        add_step(op_rd, 8'h25, 0, 0);               // neighbour axis untouched
        end_test("encoder count");

        add_step(op_aper, 8'h10, 200, 0);
        add_step(op_near, 8'h16, 0, 200 >> enc_tick_w);
        end_test("encoder period");

        add_step(op_wr, 8'h00, 32'h0, 0);           // amps enabled
        add_step(op_wr, 8'h03, 32'h2, 0);
        add_step(op_rd, 8'h03, 0, 32'h2);
        add_step(op_wait, 8'h00, 800, 0);           // past 3 x 256 quiet cycles
        add_step(op_rd, 8'h00, 0, status_word(pins_in, 4'h0, 1'b1, 1'b0, 1'b0, 4'hf));
        add_step(op_pins, 8'h00, 0,
                 pins_word(4'h0, 1'b0, 1'b0, 4'hf, 1'b0, 1'b0, 1'b1));
        add_step(op_wr, 8'h00, 32'h3, 0);
        add_step(op_rd, 8'h00, 0, status_word(pins_in, 4'h0, 1'b0, 1'b0, 1'b0, 4'h3));
        add_step(op_wr, 8'h03, 32'h0, 0);
        end_test("watchdog");
    endtask

    // ------------------------------------------------------------
    initial begin
        step_t     s;
        reg_data_t got;
        int        axis;
        int        total;
        sysclk   = 1'b0;
        rst_n    = 1'b0;
        host     = '0;
        board_id = '0;
        board_in = '0;
        enc_a    = '0;
        enc_b    = '0;
        build_steps();
        total = 16;
        foreach (steps[i]) total += step_cost(steps[i]);
        cycle_limit = 2 * total;

        repeat (16) @(posedge sysclk);
        rst_n <= 1'b1;

        foreach (steps[i]) begin
            s    = steps[i];
            axis = int'(s.addr[7:4]) - 1;
            @(posedge sysclk);
            host.wen <= 1'b0;                       // write pulse is one cycle
            case (s.op)
                op_wr: host <= '{addr: s.addr, wdata: s.data, wen: 1'b1};
                op_rd, op_near: begin
                    host.addr <= s.addr;
                    @(posedge sysclk);
                    @(negedge sysclk);
                    got = reg_rdata;
                    if (s.op == op_near && got + 1 >= s.exp && got <= s.exp + 1)
                        got = s.exp;                // one tick either way
                    check($sformatf("reg_rdata[%02h]", s.addr), got, s.exp);
                end
                op_pins: begin
                    @(negedge sysclk);
                    check("amp/pwr/relay/dout/sclk/mosi/csel",
                          pins_word(dout, relay_on, pwr_enable, amp_disable,
                                    dac_sclk, dac_mosi, dac_csel), s.exp);
                end
                op_in: begin
                    board_id <= s.data[19:16];
                    board_in <= board_in_t'(s.data[15:0]);
                    repeat (3) @(posedge sysclk);
                end
                op_fwd:  repeat (s.data) quad_step(axis, 1);
                op_bwd:  repeat (s.data) quad_step(axis, -1);
                op_dbl:  quad_step(axis, 2);        // both lines at once
                op_aper: a_period(axis, s.data);
                op_wait: repeat (s.data) @(posedge sysclk);
                op_frame: begin
                    while (frames.size() == 0) @(posedge sysclk);
                    check("dac frame", reg_data_t'(frames.pop_front()), s.exp);
                end
                op_done: begin
                    $display("test %0d %-15s %s (%0d errors)", n_tests + 1,
                             test_names[n_tests], test_errors == 0 ? "ok" : "FAILED",
                             test_errors);
                    n_tests++;
                    test_errors = 0;
                end
                default: ;
            endcase
        end

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
